// File: src/bp_pkg.sv
// Branch predictor definitions
package bp_pkg;

    // ******************************
    // sizes
    // ******************************
    localparam int xlen           = 32;
    localparam int btb_entries    = 32;
    localparam int btb_index_bits = $clog2(btb_entries);
    localparam int btb_tag_bits   = xlen - btb_index_bits - 2; // above index and byte offset.
    localparam int ghr_bits       = 5;
    localparam int pht_entries    = 1 << ghr_bits;

    // major opcodes seen by the predictor; anything else folds into op_other.
    typedef enum logic [6:0] {
        op_other  = 7'b0000000,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111
    } opcode_e;

    typedef enum logic {
        kind_branch = 1'b0,
        kind_jump   = 1'b1
    } entry_kind_e;

    // the top bit of the state is the predicted direction.
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } counter_e;

    function automatic opcode_e decode_opcode(input logic [6:0] raw);
        case (raw)
            7'b1100011: return op_branch;
            7'b1101111: return op_jal;
            7'b1100111: return op_jalr;
            default:    return op_other;
        endcase
    endfunction

endpackage

// File: src/bp_update_if.sv
// Resolved branch update bus
`timescale 1ns/10ps

interface bp_update_if;

    logic                       valid;     // one-cycle strobe.
    logic [bp_pkg::xlen-1:0]    pc;
    logic [bp_pkg::xlen-1:0]    target;
    logic [6:0]                 opcode;
    logic                       taken;
    logic [bp_pkg::ghr_bits-1:0] pht_index; // index saved at fetch time.

    // the execute side drives the fields.
    modport source (
        output valid,
        output pc,
        output target,
        output opcode,
        output taken,
        output pht_index
    );

    // the BTB and the direction predictor both listen.
    modport sink (
        input valid,
        input pc,
        input target,
        input opcode,
        input taken,
        input pht_index
    );

endinterface

// File: src/branch_target_buffer.sv
// Branch target buffer
`timescale 1ns/10ps

module branch_target_buffer (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic [bp_pkg::xlen-1:0]     pc_i,
    bp_update_if.sink                   upd,
    output logic                        hit_o,
    output bp_pkg::entry_kind_e         kind_o,
    output logic [bp_pkg::xlen-1:0]     target_o
);

    logic                               valid_q  [bp_pkg::btb_entries];
    logic [bp_pkg::btb_tag_bits-1:0]    tag_q    [bp_pkg::btb_entries];
    bp_pkg::entry_kind_e                kind_q   [bp_pkg::btb_entries];
    logic [bp_pkg::xlen-1:0]            target_q [bp_pkg::btb_entries];

    logic [bp_pkg::btb_index_bits-1:0]  rd_index;
    logic [bp_pkg::btb_tag_bits-1:0]    rd_tag;
    logic [bp_pkg::btb_index_bits-1:0]  wr_index;
    logic [bp_pkg::btb_tag_bits-1:0]    wr_tag;
    bp_pkg::opcode_e                    upd_op;
    logic                               wr_en;
    bp_pkg::entry_kind_e                wr_kind;

    // ******************************
    // lookup
    // ******************************
    assign rd_index = pc_i[bp_pkg::btb_index_bits+1:2];
    assign rd_tag   = pc_i[bp_pkg::xlen-1:bp_pkg::btb_index_bits+2];

    assign hit_o    = valid_q[rd_index] && (tag_q[rd_index] == rd_tag);
    assign kind_o   = kind_q[rd_index];
    assign target_o = target_q[rd_index];

    // ******************************
    // install
    // ******************************
    assign wr_index = upd.pc[bp_pkg::btb_index_bits+1:2];
    assign wr_tag   = upd.pc[bp_pkg::xlen-1:bp_pkg::btb_index_bits+2];
    assign upd_op   = bp_pkg::decode_opcode(upd.opcode);

    // Every control transfer gets an entry, a conditional one as a branch.
    always_comb begin
        wr_en   = 1'b0;
        wr_kind = bp_pkg::kind_branch;
        case (upd_op)
            bp_pkg::op_branch: begin
                wr_en = upd.valid;
            end
            bp_pkg::op_jal, bp_pkg::op_jalr: begin
                wr_en   = upd.valid;
                wr_kind = bp_pkg::kind_jump;
            end
            default: begin
                wr_en = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < bp_pkg::btb_entries; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid_q[wr_index] <= 1'b1; // overwrites whatever lived at this index.
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_index]    <= wr_tag;
            kind_q[wr_index]   <= wr_kind;
            target_q[wr_index] <= upd.target;
        end
    end

endmodule

// File: src/gshare_predictor.sv
// Gshare direction predictor
`timescale 1ns/10ps

module gshare_predictor (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic [bp_pkg::xlen-1:0]         pc_i,
    input  logic                            ghr_clear_i,
    bp_update_if.sink                       upd,
    output bp_pkg::counter_e                counter_o,
    output logic [bp_pkg::ghr_bits-1:0]     pht_index_o
);

    logic [bp_pkg::ghr_bits-1:0]    ghr_q;
    bp_pkg::counter_e               pht_q [bp_pkg::pht_entries];

    logic                           branch_upd;
    bp_pkg::counter_e               pht_cur;
    bp_pkg::counter_e               pht_next;

    // ******************************
    // lookup
    // ******************************
    assign pht_index_o = pc_i[bp_pkg::ghr_bits+1:2] ^ ghr_q;
    assign counter_o   = pht_q[pht_index_o];

    // only conditional branches train the counters and the history.
    assign branch_upd = upd.valid && (bp_pkg::decode_opcode(upd.opcode) == bp_pkg::op_branch);

    // the index comes back from the pipeline, not from the current history.
    assign pht_cur = pht_q[upd.pht_index];

    always_comb begin
        pht_next = pht_cur;
        if (upd.taken) begin
            if (pht_cur != bp_pkg::strong_taken) begin
                pht_next = bp_pkg::counter_e'(pht_cur + 2'd1);
            end
        end else begin
            if (pht_cur != bp_pkg::strong_not_taken) begin
                pht_next = bp_pkg::counter_e'(pht_cur - 2'd1);
            end
        end
    end

    // ******************************
    // state
    // ******************************
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < bp_pkg::pht_entries; i++) begin
                pht_q[i] <= bp_pkg::weak_not_taken;
            end
        end else if (branch_upd) begin
            pht_q[upd.pht_index] <= pht_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || ghr_clear_i) begin
            ghr_q <= '0; // a clear wins over a shift in the same cycle.
        end else if (branch_upd) begin
            ghr_q <= {ghr_q[bp_pkg::ghr_bits-2:0], upd.taken};
        end
    end

endmodule

// File: src/fetch_redirect.sv
// Next fetch address select
`timescale 1ns/10ps

module fetch_redirect (
    input  logic [bp_pkg::xlen-1:0]     pc_i,
    input  logic                        hit_i,
    input  bp_pkg::entry_kind_e         kind_i,
    input  bp_pkg::counter_e            counter_i,
    input  logic [bp_pkg::xlen-1:0]     target_i,
    output logic                        taken_o,
    output logic [bp_pkg::xlen-1:0]     next_pc_o
);

    logic                       jump_hit;
    logic                       branch_hit;
    logic                       predict_taken;
    logic [bp_pkg::xlen-1:0]    seq_pc;

    assign predict_taken = counter_i[1]; // top bit of the counter is the direction.

    // jumps are always taken; branches follow their counter.
    assign jump_hit   = hit_i && (kind_i == bp_pkg::kind_jump);
    assign branch_hit = hit_i && (kind_i == bp_pkg::kind_branch) && predict_taken;

    assign taken_o = jump_hit || branch_hit;

    // a miss or a not-taken branch just falls through.
    assign seq_pc    = pc_i + bp_pkg::xlen'(4);
    assign next_pc_o = taken_o ? target_i : seq_pc;

endmodule

// File: src/branch_predictor_top.sv
// Fetch stage branch predictor
`timescale 1ns/10ps

module branch_predictor_top (
    input  logic                            clk,
    input  logic                            reset_i,

    // fetch side.
    input  logic [bp_pkg::xlen-1:0]         pc_i,
    output logic                            taken_o,
    output logic [bp_pkg::xlen-1:0]         next_pc_o,
    output logic [bp_pkg::ghr_bits-1:0]     pht_index_o,

    // resolved transfers from execute.
    input  logic                            update_valid_i,
    input  logic [bp_pkg::xlen-1:0]         update_pc_i,
    input  logic [bp_pkg::xlen-1:0]         update_target_i,
    input  logic [6:0]                      update_opcode_i,
    input  logic                            update_taken_i,
    input  logic [bp_pkg::ghr_bits-1:0]     update_pht_index_i,
    input  logic                            ghr_clear_i
);

    logic                       btb_hit;
    bp_pkg::entry_kind_e        btb_kind;
    logic [bp_pkg::xlen-1:0]    btb_target;
    bp_pkg::counter_e           gs_counter;

    // ******************************
    // update bus
    // ******************************
    bp_update_if upd_if ();

    assign upd_if.valid     = update_valid_i;
    assign upd_if.pc        = update_pc_i;
    assign upd_if.target    = update_target_i;
    assign upd_if.opcode    = update_opcode_i;
    assign upd_if.taken     = update_taken_i;
    assign upd_if.pht_index = update_pht_index_i;

    // ******************************
    // predictor parts
    // ******************************
    branch_target_buffer u_btb (
        .clk      (clk),
        .reset_i  (reset_i),
        .pc_i     (pc_i),
        .upd      (upd_if.sink),
        .hit_o    (btb_hit),
        .kind_o   (btb_kind),
        .target_o (btb_target)
    );

    gshare_predictor u_gshare (
        .clk         (clk),
        .reset_i     (reset_i),
        .pc_i        (pc_i),
        .ghr_clear_i (ghr_clear_i),
        .upd         (upd_if.sink),
        .counter_o   (gs_counter),
        .pht_index_o (pht_index_o) // carried down the pipe and returned with the update.
    );

    fetch_redirect u_redirect (
        .pc_i      (pc_i),
        .hit_i     (btb_hit),
        .kind_i    (btb_kind),
        .counter_i (gs_counter),
        .target_i  (btb_target),
        .taken_o   (taken_o),
        .next_pc_o (next_pc_o)
    );

endmodule

// File: testbench/branch_predictor_sva.sv
// Branch predictor assertions
`timescale 1ns/10ps

module branch_predictor_sva (
    input logic                         clk,
    input logic                         reset_i,
    input logic [bp_pkg::xlen-1:0]      pc_i,
    input logic                         taken_i,
    input logic [bp_pkg::xlen-1:0]      next_pc_i,
    input logic [bp_pkg::ghr_bits-1:0]  pht_index_i,
    input logic                         update_valid_i,
    input logic [6:0]                   update_opcode_i,
    input logic                         update_taken_i,
    input logic                         ghr_clear_i
);

    int failures = 0;
    logic [bp_pkg::ghr_bits-1:0] hist_seen;

    // the history is recovered from the exported index and the fetch pc.
    assign hist_seen = pht_index_i ^ pc_i[bp_pkg::ghr_bits+1:2];

    fall_through: assert property (@(posedge clk) disable iff (reset_i)
        !taken_i |-> next_pc_i == pc_i + 32'd4)
        else begin failures++; $error("next pc is not pc+4 on a not-taken lookup."); end

    quiet_after_reset: assert property (@(posedge clk) $fell(reset_i) |-> !taken_i)
        else begin failures++; $error("a lookup was taken right after reset."); end

    history_shift: assert property (@(posedge clk) disable iff (reset_i)
        (update_valid_i && update_opcode_i == bp_pkg::op_branch && !ghr_clear_i) |=>
        hist_seen == {$past(hist_seen[bp_pkg::ghr_bits-2:0]), $past(update_taken_i)})
        else begin failures++; $error("history did not shift in the branch outcome."); end

    history_clear: assert property (@(posedge clk) disable iff (reset_i)
        ghr_clear_i |=> hist_seen == '0)
        else begin failures++; $error("history is not zero after a clear."); end

endmodule

bind branch_predictor_top branch_predictor_sva sva0 (
    .clk             (clk),
    .reset_i         (reset_i),
    .pc_i            (pc_i),
    .taken_i         (taken_o),
    .next_pc_i       (next_pc_o),
    .pht_index_i     (pht_index_o),
    .update_valid_i  (update_valid_i),
    .update_opcode_i (update_opcode_i),
    .update_taken_i  (update_taken_i),
    .ghr_clear_i     (ghr_clear_i)
);

// File: testbench/branch_predictor_tb.sv
// Branch predictor testbench
`timescale 1ns/10ps

module branch_predictor_tb;

    typedef struct packed {
        logic [31:0] pc;
        logic        upd_valid;
        logic [31:0] upd_pc;
        logic [31:0] upd_target;
        logic [6:0]  upd_opcode;
        logic        upd_taken;
        logic        ghr_clear;
        int          step;
        logic        chk;          // compare taken_o with exp_taken as well.
        logic        exp_taken;
    } row_t;

    logic        clk = 1'b0;
    logic        reset_i;
    logic [31:0] pc_i;
    logic        taken_o;
    logic [31:0] next_pc_o;
    logic [4:0]  pht_index_o;
    logic        update_valid_i;
    logic [31:0] update_pc_i;
    logic [31:0] update_target_i;
    logic [6:0]  update_opcode_i;
    logic        update_taken_i;
    logic [4:0]  update_pht_index_i;
    logic        ghr_clear_i;

    // reference model state.
    logic        m_valid  [32];
    logic [24:0] m_tag    [32];
    logic        m_kind   [32];     // 1 for a jump.
    logic [31:0] m_target [32];
    logic [1:0]  m_pht    [32];
    logic [4:0]  m_ghr;

    logic [4:0]  saved_index [logic [31:0]]; // pht_index_o seen at the last fetch of a pc.
    logic [4:0]  sent_index;
    row_t        rows [$];
    logic [31:0] rng = 32'h30be_b4f5;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    branch_predictor_top dut0 (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            $display("ERROR: the run did not finish within %0d cycles.", cycle_limit);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_row(input logic [31:0] pc, input logic uv, input logic [31:0] upc,
                           input logic [31:0] tgt, input logic [6:0] op, input logic tk,
                           input logic clr, input int step, input logic chk, input logic exp);
        rows.push_back('{pc, uv, upc, tgt, op, tk, clr, step, chk, exp});
    endtask

    task automatic add_lookup(input logic [31:0] pc, input int step, input logic exp);
        add_row(pc, 1'b0, 32'd0, 32'd0, 7'd0, 1'b0, 1'b0, step, 1'b1, exp);
    endtask

    // ******************************
    // stimulus table
    // ******************************
    task automatic build_table();
        logic [31:0] pool [8];
        logic [31:0] pc;
        logic [31:0] prev_pc;
        logic [6:0]  op;
        logic [6:0]  ops [4];
        // index 16 shared by the jal and its alias, 18 for the jalr, 1 for the branch.
        logic [31:0] pc_j  = 32'h0000_1040;
        logic [31:0] pc_ja = 32'h0000_5040;
        logic [31:0] pc_r  = 32'h0000_10c8;
        logic [31:0] pc_b  = 32'h0000_1104;
        ops[0] = bp_pkg::op_branch;
        ops[1] = bp_pkg::op_jal;
        ops[2] = bp_pkg::op_jalr;
        ops[3] = 7'b0010011;          // an ALU immediate op, no control transfer.
        add_lookup(pc_j, 1, 1'b0);
        add_lookup(pc_ja, 1, 1'b0);
        add_lookup(pc_b, 1, 1'b0);
        add_lookup(pc_r, 1, 1'b0);
        add_row(pc_j, 1'b1, pc_j, 32'h0000_2000, bp_pkg::op_jal, 1'b1, 1'b0, 2, 1'b1, 1'b0);
        add_lookup(pc_j, 2, 1'b1);
        add_lookup(pc_ja, 2, 1'b0);
        add_row(pc_r, 1'b1, pc_r, 32'h0000_3000, bp_pkg::op_jalr, 1'b1, 1'b0, 2, 1'b1, 1'b0);
        add_lookup(pc_r, 2, 1'b1);
        // the clear keeps history at zero so every branch update trains index 1.
        add_lookup(pc_b, 3, 1'b0);
        add_row(pc_b, 1'b1, pc_b, 32'h0000_1200, bp_pkg::op_branch, 1'b0, 1'b1, 3, 1'b1, 1'b0);
        add_row(pc_b, 1'b1, pc_b, 32'h0000_1200, bp_pkg::op_branch, 1'b1, 1'b1, 3, 1'b1, 1'b0);
        add_lookup(pc_b, 3, 1'b0);
        for (int i = 0; i < 4; i++) begin
            add_row(pc_b, 1'b1, pc_b, 32'h0000_1200, bp_pkg::op_branch, i < 3, 1'b1, 3,
                    1'b1, i > 0);
        end
        add_lookup(pc_b, 3, 1'b1);
        add_lookup(pc_b, 4, 1'b1);
        add_row(pc_b, 1'b1, pc_b, 32'h0000_1200, bp_pkg::op_branch, 1'b1, 1'b0, 4, 1'b1, 1'b1);
        add_lookup(pc_b, 4, 1'b0);
        add_row(pc_b, 1'b1, pc_b, 32'h0000_1200, bp_pkg::op_branch, 1'b1, 1'b0, 4, 1'b1, 1'b0);
        add_lookup(pc_b, 4, 1'b0);
        add_row(pc_b, 1'b0, 32'd0, 32'd0, 7'd0, 1'b0, 1'b1, 4, 1'b1, 1'b0);
        add_lookup(pc_b, 4, 1'b1);
        add_row(pc_r, 1'b1, pc_r, 32'h0000_9000, 7'b0010011, 1'b1, 1'b0, 5, 1'b1, 1'b1);
        add_lookup(pc_r, 5, 1'b1);
        add_lookup(pc_b, 5, 1'b1);
        add_row(pc_ja, 1'b1, pc_ja, 32'h0000_4000, bp_pkg::op_jal, 1'b1, 1'b0, 5, 1'b1, 1'b0);
        add_lookup(pc_ja, 5, 1'b1);
        add_lookup(pc_j, 5, 1'b0);
        for (int i = 0; i < 8; i++) begin
            rng = xorshift32(rng);
            pool[i] = rng & 32'h0000_3ffc; // narrow tags so entries collide now and then.
        end
        prev_pc = pc_j;
        for (int i = 0; i < 200; i++) begin
            rng = xorshift32(rng);
            pc = pool[rng[2:0]];
            op = ops[rng[4:3]];
            add_row(pc, rng[5], prev_pc, rng & 32'h0000_fffc, op, rng[6], rng[11:8] == 4'd0,
                    6, 1'b0, 1'b0);
            prev_pc = pc;
        end
    endtask

    // ******************************
    // reference model
    // ******************************
    task automatic reset_model();
        for (int i = 0; i < 32; i++) begin
            m_valid[i] = 1'b0;
            m_pht[i]   = 2'b01;
        end
        m_ghr = 5'd0;
    endtask

    task automatic apply_update(input row_t r);
        logic [4:0] idx;
        logic       is_branch;
        logic       is_jump;
        idx       = r.upd_pc[6:2];
        is_branch = r.upd_valid && (r.upd_opcode == bp_pkg::op_branch);
        is_jump   = r.upd_valid && (r.upd_opcode == bp_pkg::op_jal ||
                                    r.upd_opcode == bp_pkg::op_jalr);
        if (is_branch || is_jump) begin
            m_valid[idx]  = 1'b1;
            m_tag[idx]    = r.upd_pc[31:7];
            m_kind[idx]   = is_jump;
            m_target[idx] = r.upd_target;
        end
        if (is_branch && r.upd_taken && m_pht[sent_index] != 2'b11) begin
            m_pht[sent_index] = m_pht[sent_index] + 2'd1;
        end else if (is_branch && !r.upd_taken && m_pht[sent_index] != 2'b00) begin
            m_pht[sent_index] = m_pht[sent_index] - 2'd1;
        end
        if (r.ghr_clear) begin
            m_ghr = 5'd0;
        end else if (is_branch) begin
            m_ghr = {m_ghr[3:0], r.upd_taken};
        end
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp, input int step);
        $display("MISMATCH at %0t ns: step %0d, %s is %h, expected %h", $time, step, what,
                 got, exp);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_outputs(input row_t r);
        logic [4:0]  idx;
        logic [4:0]  gidx;
        logic        hit;
        logic        exp_taken;
        logic [31:0] exp_pc;
        idx       = r.pc[6:2];
        gidx      = idx ^ m_ghr;
        hit       = m_valid[idx] && (m_tag[idx] == r.pc[31:7]);
        exp_taken = hit && (m_kind[idx] || m_pht[gidx][1]);
        exp_pc    = exp_taken ? m_target[idx] : r.pc + 32'd4;
        assert (taken_o === exp_taken)
            else report_mismatch("taken_o", 32'(taken_o), 32'(exp_taken), r.step);
        assert (!r.chk || taken_o === r.exp_taken)
            else report_mismatch("taken_o (table)", 32'(taken_o), 32'(r.exp_taken), r.step);
        assert (next_pc_o === exp_pc)
            else report_mismatch("next_pc_o", next_pc_o, exp_pc, r.step);
        assert (pht_index_o === gidx)
            else report_mismatch("pht_index_o", 32'(pht_index_o), 32'(gidx), r.step);
    endtask

    task automatic drive_row(input row_t r);
        if (saved_index.exists(r.upd_pc)) begin
            sent_index = saved_index[r.upd_pc];
        end else begin
            sent_index = r.upd_pc[6:2] ^ m_ghr;
        end
        pc_i               = r.pc;
        update_valid_i     = r.upd_valid;
        update_pc_i        = r.upd_pc;
        update_target_i    = r.upd_target;
        update_opcode_i    = r.upd_opcode;
        update_taken_i     = r.upd_taken;
        update_pht_index_i = sent_index;
        ghr_clear_i        = r.ghr_clear;
    endtask

    initial begin
        reset_i = 1'b1;
        reset_model();
        drive_row('0);
        build_table();
        cycle_limit = rows.size() + 10 + 50;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            @(negedge clk);
            drive_row(rows[i]);
            #1;
            check_outputs(rows[i]);
            saved_index[rows[i].pc] = pht_index_o;
            @(posedge clk);
            apply_update(rows[i]);
        end
        @(posedge clk); // the last update's next-cycle assertions are sampled here.
        @(negedge clk);
        if (dut0.sva0.failures == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("ERROR: %0d concurrent assertions failed.", dut0.sva0.failures);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

endmodule

// File: vlog.f
src/bp_pkg.sv
src/bp_update_if.sv
src/branch_target_buffer.sv
src/gshare_predictor.sv
src/fetch_redirect.sv
src/branch_predictor_top.sv
testbench/branch_predictor_sva.sv
testbench/branch_predictor_tb.sv

// File: Makefile
# Verilator build for the branch predictor

VERILATOR ?= verilator
FLAGS     := --timing --assert
TOP       := branch_predictor_tb
FILELIST  := vlog.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
